// ==== hw/wb_macros.svh ====
// Write-back macros
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////

// Integer data word width of the core
`define WB_XLEN 32

// Register index width for the integer register file
`define WB_RF_AW 5

// Number of architectural registers, derived from the index width
`define WB_RF_NREGS (1 << `WB_RF_AW)

`endif

// ==== hw/wb_pipe_pkg.sv ====
// Write-back pipeline types
`include "wb_macros.svh"

package wb_pipe_pkg;

  //////////////////////////////////////////////////
  // Pipeline fields
  //////////////////////////////////////////////////

  // Index into the integer register file
  typedef logic [`WB_RF_AW-1:0] rf_addr_t;

  // Where the write-back result comes from
  // EXE instructions may still be overridden by a pending pointer
  typedef enum logic [1:0] {
    SRC_EXE = 2'd0,
    SRC_LSU = 2'd1,
    SRC_XIF = 2'd2
  } wb_src_e;

  // Status returned by the MPU alongside load data
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  //////////////////////////////////////////////////
  // Configuration space
  //////////////////////////////////////////////////

  // Word addresses of the write-back control registers
  typedef enum logic [1:0] {
    CFG_HALT   = 2'd0,
    CFG_PTR    = 2'd1,
    CFG_EXC    = 2'd2,
    CFG_RETIRE = 2'd3
  } cfg_addr_e;

endpackage

// ==== hw/wb_xif_pkg.sv ====
// Coprocessor result types
`include "wb_macros.svh"

package wb_xif_pkg;

  //////////////////////////////////////////////////
  // Exception view of the result word
  //////////////////////////////////////////////////

  // Synchronous exception code reported by the coprocessor
  typedef logic [5:0] xif_ecode_t;

  // Code sits in the top bits, the low part of tval fills the rest
  typedef struct packed {
    xif_ecode_t                              code;
    logic [`WB_XLEN-$bits(xif_ecode_t)-1:0] tval_lo;
  } xif_exc_t;

  //////////////////////////////////////////////////
  // Result word
  //////////////////////////////////////////////////

  // One word with two readings
  // The exception flag that travels next to it picks the view
  typedef union packed {
    logic [`WB_XLEN-1:0] data;
    xif_exc_t            exc;
  } xif_result_u;

endpackage

// ==== hw/ex_wb_pipe_reg.sv ====
// EX/WB pipeline register
`timescale 1ns/1ps
`include "wb_macros.svh"

module ex_wb_pipe_reg (
  input  logic                   clk,
  input  logic                   rst_i,

  // Execute side
  input  logic                   ex_valid_i,
  input  wb_pipe_pkg::wb_src_e   ex_src_i,
  input  logic                   ex_rf_we_i,
  input  wb_pipe_pkg::rf_addr_t  ex_rf_waddr_i,
  input  logic [`WB_XLEN-1:0]    ex_wdata_i,
  input  logic                   ex_last_op_i,
  output logic                   ex_ready_o,

  // Write-back side
  input  logic                   wb_ready_i,
  output logic                   pipe_valid_o,
  output wb_pipe_pkg::wb_src_e   pipe_src_o,
  output logic                   pipe_rf_we_o,
  output wb_pipe_pkg::rf_addr_t  pipe_rf_waddr_o,
  output logic [`WB_XLEN-1:0]    pipe_wdata_o,
  output logic                   pipe_last_op_o
);

  logic transfer;

  // Room for a new instruction when empty or when the held one leaves this cycle
  assign ex_ready_o = !pipe_valid_o || wb_ready_i;
  assign transfer   = ex_valid_i && ex_ready_o;

  //////////////////////////////////////////////////
  // Occupancy flag
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pipe_valid_o <= 1'b0;
    end else if (transfer) begin
      pipe_valid_o <= 1'b1;
    end else if (wb_ready_i) begin
      // Held instruction retired and nothing replaced it
      pipe_valid_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  // Fields only move on a transfer, so a stall keeps them
  always_ff @(posedge clk) begin
    if (transfer) begin
      pipe_src_o      <= ex_src_i;
      pipe_rf_we_o    <= ex_rf_we_i;
      pipe_rf_waddr_o <= ex_rf_waddr_i;
      pipe_wdata_o    <= ex_wdata_i;
      pipe_last_op_o  <= ex_last_op_i;
    end
  end

  // A stalled instruction must look the same to WB on the next cycle
  a_hold_stable : assert property (
    @(posedge clk) disable iff (rst_i)
    (pipe_valid_o && !wb_ready_i) |=>
      ($stable(pipe_src_o) && $stable(pipe_rf_we_o) && $stable(pipe_rf_waddr_o) &&
       $stable(pipe_wdata_o) && $stable(pipe_last_op_o) && pipe_valid_o)
  ) else $error("EX/WB contents changed while the stage was stalled");

endmodule

// ==== hw/wb_stage.sv ====
// Write-back stage
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_stage (
  // Clock and reset feed the assertions only
  input  logic                      clk,
  input  logic                      rst_i,

  // EX/WB pipeline
  input  logic                      pipe_valid_i,
  input  wb_pipe_pkg::wb_src_e      pipe_src_i,
  input  logic                      pipe_rf_we_i,
  input  wb_pipe_pkg::rf_addr_t     pipe_rf_waddr_i,
  input  logic [`WB_XLEN-1:0]       pipe_wdata_i,
  input  logic                      pipe_last_op_i,

  // LSU response
  input  logic                      lsu_valid_i,
  input  logic [`WB_XLEN-1:0]       lsu_rdata_i,
  input  wb_pipe_pkg::mpu_status_e  lsu_mpu_status_i,
  output logic                      lsu_valid_o,

  // Coprocessor result
  input  logic                      xif_result_valid_i,
  input  wb_xif_pkg::xif_result_u   xif_result_i,
  input  logic                      xif_result_exc_i,
  output logic                      xif_result_ready_o,

  // From the control registers
  input  logic                      halt_i,
  input  logic [`WB_XLEN-1:0]       ptr_value_i,
  input  logic                      ptr_valid_i,

  // Register file write port
  output logic                      rf_we_o,
  output wb_pipe_pkg::rf_addr_t     rf_waddr_o,
  output logic [`WB_XLEN-1:0]       rf_wdata_o,

  // Stage status
  output logic                      wb_ready_o,
  output logic                      wb_valid_o,
  output logic                      data_stall_o,
  output logic                      abort_op_o,
  output logic                      last_op_o,

  // Events for the control registers
  output logic                      xif_exc_take_o,
  output wb_xif_pkg::xif_ecode_t    xif_exc_code_o,
  output logic                      ptr_used_o
);

  logic instr_valid;
  logic is_exe;
  logic is_lsu;
  logic is_xif;
  logic lsu_waiting;
  logic lsu_fault;
  logic xif_waiting;
  logic xif_exception;

  // Halt freezes the instruction in place without dropping it
  assign instr_valid = pipe_valid_i && !halt_i;

  assign is_exe = (pipe_src_i == wb_pipe_pkg::SRC_EXE);
  assign is_lsu = (pipe_src_i == wb_pipe_pkg::SRC_LSU);
  assign is_xif = (pipe_src_i == wb_pipe_pkg::SRC_XIF);

  //////////////////////////////////////////////////
  // Response tracking
  //////////////////////////////////////////////////

  // A held load waits for its data beat
  assign lsu_waiting = pipe_valid_i && is_lsu && !lsu_valid_i;

  // MPU status only means something on the beat that carries it
  assign lsu_fault = instr_valid && is_lsu && lsu_valid_i &&
                     (lsu_mpu_status_i != wb_pipe_pkg::MPU_OK);

  // Coprocessor instructions sit here until their result shows up
  assign xif_waiting   = pipe_valid_i && is_xif && !xif_result_valid_i;
  assign xif_exception = instr_valid && is_xif && xif_result_valid_i && xif_result_exc_i;

  // Requests go out as soon as the instruction is held, even under halt
  assign lsu_valid_o        = pipe_valid_i && is_lsu;
  assign xif_result_ready_o = pipe_valid_i && is_xif;

  //////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////

  // Faults and exceptions leave the destination untouched
  assign rf_we_o = pipe_rf_we_i && instr_valid && !lsu_waiting && !lsu_fault &&
                   !xif_waiting && !xif_exception;

  assign rf_waddr_o = pipe_rf_waddr_i;

  // Pending pointer value only replaces execute results
  assign rf_wdata_o = is_lsu      ? lsu_rdata_i       :
                      is_xif      ? xif_result_i.data :
                      ptr_valid_i ? ptr_value_i       :
                                    pipe_wdata_i;

  //////////////////////////////////////////////////
  // Stage handshake and status
  //////////////////////////////////////////////////

  // Nothing downstream, so only halt or an outstanding response holds WB
  assign wb_ready_o = !halt_i && !lsu_waiting && !xif_waiting;

  // Faulted loads and coprocessor exceptions still count as valid here
  assign wb_valid_o = ((!is_lsu && !xif_waiting) || (is_lsu && lsu_valid_i)) && instr_valid;

  assign data_stall_o = is_lsu && !lsu_valid_i && instr_valid;
  assign abort_op_o   = lsu_fault || xif_exception;
  assign last_op_o    = pipe_last_op_i && pipe_valid_i;

  // Exception cause rides in the result word when the flag is set
  assign xif_exc_take_o = xif_exception;
  assign xif_exc_code_o = xif_result_i.exc.code;

  // One execute retirement consumes the pointer
  assign ptr_used_o = wb_valid_o && is_exe && ptr_valid_i;

  // The LSU only answers a load that WB is holding
  a_lsu_resp : assert property (
    @(posedge clk) disable iff (rst_i)
    lsu_valid_i |-> lsu_valid_o
  ) else $error("LSU response arrived with no load in write-back");

  // The coprocessor only completes into a ready slot
  a_xif_resp : assert property (
    @(posedge clk) disable iff (rst_i)
    xif_result_valid_i |-> xif_result_ready_o
  ) else $error("Coprocessor result arrived while write-back was not ready");

endmodule

// ==== hw/wb_ctrl_regs.sv ====
// Write-back control registers
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_ctrl_regs (
  input  logic                    clk,
  input  logic                    rst_i,

  // Configuration strobe and read port
  input  logic                    cfg_we_i,
  input  wb_pipe_pkg::cfg_addr_e  cfg_addr_i,
  input  logic [`WB_XLEN-1:0]     cfg_wdata_i,
  output logic [`WB_XLEN-1:0]     cfg_rdata_o,

  // Events from the stage
  input  logic                    retire_i,
  input  logic                    xif_exc_take_i,
  input  wb_xif_pkg::xif_ecode_t  xif_exc_code_i,
  input  logic                    ptr_used_i,

  // Steering outputs
  output logic                    halt_o,
  output logic [`WB_XLEN-1:0]     ptr_value_o,
  output logic                    ptr_valid_o
);

  wb_xif_pkg::xif_ecode_t exc_code_q;
  logic [`WB_XLEN-1:0]    retire_cnt_q;

  //////////////////////////////////////////////////
  // Control and status state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      halt_o       <= 1'b0;
      ptr_valid_o  <= 1'b0;
      exc_code_q   <= '0;
      retire_cnt_q <= '0;
    end else begin
      // Consumption first, so a same-cycle pointer write wins
      if (ptr_used_i) begin
        ptr_valid_o <= 1'b0;
      end
      if (xif_exc_take_i) begin
        exc_code_q <= xif_exc_code_i;
      end
      if (retire_i) begin
        retire_cnt_q <= retire_cnt_q + 1'b1;
      end
      if (cfg_we_i) begin
        case (cfg_addr_i)
          wb_pipe_pkg::CFG_HALT:   halt_o <= cfg_wdata_i[0];
          wb_pipe_pkg::CFG_PTR:    ptr_valid_o <= 1'b1;
          // Any write clears the recorded cause
          wb_pipe_pkg::CFG_EXC:    exc_code_q <= '0;
          wb_pipe_pkg::CFG_RETIRE: retire_cnt_q <= '0;
          default: ;
        endcase
      end
    end
  end

  // Pointer value loads only on a write to its own address
  always_ff @(posedge clk) begin
    if (cfg_we_i && (cfg_addr_i == wb_pipe_pkg::CFG_PTR)) begin
      ptr_value_o <= cfg_wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      wb_pipe_pkg::CFG_HALT:   cfg_rdata_o[0] = halt_o;
      wb_pipe_pkg::CFG_PTR:    cfg_rdata_o = ptr_value_o;
      wb_pipe_pkg::CFG_EXC:    cfg_rdata_o[$bits(exc_code_q)-1:0] = exc_code_q;
      wb_pipe_pkg::CFG_RETIRE: cfg_rdata_o = retire_cnt_q;
      default: ;
    endcase
  end

endmodule

// ==== hw/regfile.sv ====
// Integer register file
`timescale 1ns/1ps
`include "wb_macros.svh"

module regfile (
  input  logic                   clk,
  input  logic                   rst_i,

  // Write port from write-back
  input  logic                   we_i,
  input  wb_pipe_pkg::rf_addr_t  waddr_i,
  input  logic [`WB_XLEN-1:0]    wdata_i,

  // Combinational read port
  input  wb_pipe_pkg::rf_addr_t  raddr_i,
  output logic [`WB_XLEN-1:0]    rdata_o
);

  logic [`WB_XLEN-1:0] rf_q [`WB_RF_NREGS];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `WB_RF_NREGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // x0 is never written
      rf_q[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero regardless of the array
  assign rdata_o = (raddr_i == '0) ? '0 : rf_q[raddr_i];

endmodule

// ==== hw/wb_top.sv ====
// Write-back top level
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_top (
  input  logic                      clk,
  input  logic                      rst_i,

  // Issue from execute
  input  logic                      ex_valid_i,
  input  wb_pipe_pkg::wb_src_e      ex_src_i,
  input  logic                      ex_rf_we_i,
  input  wb_pipe_pkg::rf_addr_t     ex_rf_waddr_i,
  input  logic [`WB_XLEN-1:0]       ex_wdata_i,
  input  logic                      ex_last_op_i,
  output logic                      ex_ready_o,

  // LSU link
  output logic                      lsu_valid_o,
  input  logic                      lsu_valid_i,
  input  logic [`WB_XLEN-1:0]       lsu_rdata_i,
  input  wb_pipe_pkg::mpu_status_e  lsu_mpu_status_i,

  // Coprocessor link
  output logic                      xif_result_ready_o,
  input  logic                      xif_result_valid_i,
  input  wb_xif_pkg::xif_result_u   xif_result_i,
  input  logic                      xif_result_exc_i,

  // Configuration link
  input  logic                      cfg_we_i,
  input  wb_pipe_pkg::cfg_addr_e    cfg_addr_i,
  input  logic [`WB_XLEN-1:0]       cfg_wdata_i,
  output logic [`WB_XLEN-1:0]       cfg_rdata_o,

  // Debug read of the register file
  input  wb_pipe_pkg::rf_addr_t     rf_raddr_i,
  output logic [`WB_XLEN-1:0]       rf_rdata_o,

  // Stage status
  output logic                      wb_valid_o,
  output logic                      data_stall_o,
  output logic                      abort_op_o,
  output logic                      last_op_o
);

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  logic                   pipe_valid;
  wb_pipe_pkg::wb_src_e   pipe_src;
  logic                   pipe_rf_we;
  wb_pipe_pkg::rf_addr_t  pipe_rf_waddr;
  logic [`WB_XLEN-1:0]    pipe_wdata;
  logic                   pipe_last_op;
  logic                   wb_ready;
  logic                   rf_we;
  wb_pipe_pkg::rf_addr_t  rf_waddr;
  logic [`WB_XLEN-1:0]    rf_wdata;
  logic                   xif_exc_take;
  wb_xif_pkg::xif_ecode_t xif_exc_code;
  logic                   ptr_used;
  logic                   halt;
  logic [`WB_XLEN-1:0]    ptr_value;
  logic                   ptr_valid;

  ex_wb_pipe_reg u_pipe_reg (
    .clk             (clk),
    .rst_i           (rst_i),
    .ex_valid_i      (ex_valid_i),
    .ex_src_i        (ex_src_i),
    .ex_rf_we_i      (ex_rf_we_i),
    .ex_rf_waddr_i   (ex_rf_waddr_i),
    .ex_wdata_i      (ex_wdata_i),
    .ex_last_op_i    (ex_last_op_i),
    .ex_ready_o      (ex_ready_o),
    .wb_ready_i      (wb_ready),
    .pipe_valid_o    (pipe_valid),
    .pipe_src_o      (pipe_src),
    .pipe_rf_we_o    (pipe_rf_we),
    .pipe_rf_waddr_o (pipe_rf_waddr),
    .pipe_wdata_o    (pipe_wdata),
    .pipe_last_op_o  (pipe_last_op)
  );

  // Every valid write-back counts as a retirement
  wb_stage u_wb_stage (
    .clk                (clk),
    .rst_i              (rst_i),
    .pipe_valid_i       (pipe_valid),
    .pipe_src_i         (pipe_src),
    .pipe_rf_we_i       (pipe_rf_we),
    .pipe_rf_waddr_i    (pipe_rf_waddr),
    .pipe_wdata_i       (pipe_wdata),
    .pipe_last_op_i     (pipe_last_op),
    .lsu_valid_i        (lsu_valid_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .lsu_mpu_status_i   (lsu_mpu_status_i),
    .lsu_valid_o        (lsu_valid_o),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_i       (xif_result_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .xif_result_ready_o (xif_result_ready_o),
    .halt_i             (halt),
    .ptr_value_i        (ptr_value),
    .ptr_valid_i        (ptr_valid),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_ready_o         (wb_ready),
    .wb_valid_o         (wb_valid_o),
    .data_stall_o       (data_stall_o),
    .abort_op_o         (abort_op_o),
    .last_op_o          (last_op_o),
    .xif_exc_take_o     (xif_exc_take),
    .xif_exc_code_o     (xif_exc_code),
    .ptr_used_o         (ptr_used)
  );

  wb_ctrl_regs u_ctrl_regs (
    .clk            (clk),
    .rst_i          (rst_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .retire_i       (wb_valid_o),
    .xif_exc_take_i (xif_exc_take),
    .xif_exc_code_i (xif_exc_code),
    .ptr_used_i     (ptr_used),
    .halt_o         (halt),
    .ptr_value_o    (ptr_value),
    .ptr_valid_o    (ptr_valid)
  );

  regfile u_regfile (
    .clk     (clk),
    .rst_i   (rst_i),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

// ==== testbench/tb_wb_top.sv ====
// Write-back testbench
`timescale 1ns/1ps
`include "wb_macros.svh"

module tb_wb_top;

  localparam int CLK_NS       = 40;
  localparam int RESET_CYCLES = 5;
  localparam int EXE_OPS      = 12;
  localparam int LSU_WAIT     = 5;
  localparam int XIF_WAIT     = 4;
  localparam int HALT_CYCLES  = 6;
  // Instructions sent and config or register accesses over all tests
  localparam int NUM_OPS      = EXE_OPS + 10;
  localparam int NUM_ACCESSES = 28;
  // An instruction needs at most 4 cycles without a wait, an access 2
  localparam int TEST_CYCLES  = RESET_CYCLES + 4 * NUM_OPS + 2 * NUM_ACCESSES +
                                LSU_WAIT + 2 * XIF_WAIT + HALT_CYCLES;
  localparam int WATCHDOG_NS  = (2 * TEST_CYCLES + 50) * CLK_NS;

  logic                     clk;
  logic                     rst_i;
  logic                     ex_valid_i;
  wb_pipe_pkg::wb_src_e     ex_src_i;
  logic                     ex_rf_we_i;
  wb_pipe_pkg::rf_addr_t    ex_rf_waddr_i;
  logic [`WB_XLEN-1:0]      ex_wdata_i;
  logic                     ex_last_op_i;
  logic                     ex_ready_o;
  logic                     lsu_valid_o;
  logic                     lsu_valid_i;
  logic [`WB_XLEN-1:0]      lsu_rdata_i;
  wb_pipe_pkg::mpu_status_e lsu_mpu_status_i;
  logic                     xif_result_ready_o;
  logic                     xif_result_valid_i;
  wb_xif_pkg::xif_result_u  xif_result_i;
  logic                     xif_result_exc_i;
  logic                     cfg_we_i;
  wb_pipe_pkg::cfg_addr_e   cfg_addr_i;
  logic [`WB_XLEN-1:0]      cfg_wdata_i;
  logic [`WB_XLEN-1:0]      cfg_rdata_o;
  wb_pipe_pkg::rf_addr_t    rf_raddr_i;
  logic [`WB_XLEN-1:0]      rf_rdata_o;
  logic                     wb_valid_o;
  logic                     data_stall_o;
  logic                     abort_op_o;
  logic                     last_op_o;

  // Scoreboard state built from the register-file rules
  logic [`WB_XLEN-1:0]      model_rf [`WB_RF_NREGS];
  int                       model_retires;
  logic [31:0]              lfsr_state;
  int                       val_errs;
  int                       proto_errs;
  string                    test_name;

  // Check enables and expected values for the assertions
  logic                     chk_reg;
  logic                     chk_cfg;
  logic                     lsu_wait_chk;
  logic                     xif_wait_chk;
  logic                     halt_chk;
  logic                     abort_ok;
  logic                     exp_last;
  logic [`WB_XLEN-1:0]      exp_reg;
  logic [`WB_XLEN-1:0]      exp_cfg;

  // Stimulus scratch values
  wb_pipe_pkg::rf_addr_t    addr_a;
  wb_pipe_pkg::rf_addr_t    addr_b;
  logic [`WB_XLEN-1:0]      data_a;
  logic [`WB_XLEN-1:0]      rnd;
  wb_xif_pkg::xif_ecode_t   exc_code;
  wb_xif_pkg::xif_result_u  xif_word;

  wb_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Stops a run that stopped making progress
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the tests did not finish in %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR, one step for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Random destination that is never x0
  function automatic wb_pipe_pkg::rf_addr_t rand_reg();
    logic [31:0] r;
    r = rand_bits(`WB_RF_AW);
    return (r[`WB_RF_AW-1:0] == '0) ? wb_pipe_pkg::rf_addr_t'(1) : r[`WB_RF_AW-1:0];
  endfunction

  // x0 never changes in the model
  task automatic model_write(input wb_pipe_pkg::rf_addr_t addr, input logic [31:0] data);
    if (addr != '0) model_rf[addr] = data;
  endtask

  // Offers one instruction and returns at the falling edge after its transfer
  task automatic send_op(input wb_pipe_pkg::wb_src_e src, input logic we,
                         input wb_pipe_pkg::rf_addr_t addr, input logic [31:0] data);
    @(negedge clk);
    ex_valid_i    = 1'b1;
    ex_src_i      = src;
    ex_rf_we_i    = we;
    ex_rf_waddr_i = addr;
    ex_wdata_i    = data;
    #1;
    while (!ex_ready_o) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ex_valid_i = 1'b0;
    // Every instruction retires exactly once
    model_retires++;
  endtask

  // Waits for the retire edge of the held instruction
  task automatic wait_retire();
    #1;
    while (!wb_valid_o) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
  endtask

  // Data beat from the LSU, caller sits on a falling edge
  task automatic lsu_respond(input logic [31:0] data, input wb_pipe_pkg::mpu_status_e st);
    lsu_valid_i      = 1'b1;
    lsu_rdata_i      = data;
    lsu_mpu_status_i = st;
    @(negedge clk);
    lsu_valid_i      = 1'b0;
    lsu_mpu_status_i = wb_pipe_pkg::MPU_OK;
  endtask

  // Result beat from the coprocessor, caller sits on a falling edge
  task automatic xif_respond(input wb_xif_pkg::xif_result_u word, input logic exc);
    xif_result_valid_i = 1'b1;
    xif_result_i       = word;
    xif_result_exc_i   = exc;
    @(negedge clk);
    xif_result_valid_i = 1'b0;
    xif_result_exc_i   = 1'b0;
  endtask

  task automatic write_cfg(input wb_pipe_pkg::cfg_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  task automatic expect_cfg(input wb_pipe_pkg::cfg_addr_e addr, input logic [31:0] exp,
                            input string name);
    @(negedge clk);
    cfg_addr_i = addr;
    exp_cfg    = exp;
    test_name  = name;
    chk_cfg    = 1'b1;
    @(negedge clk);
    chk_cfg = 1'b0;
  endtask

  task automatic expect_reg(input wb_pipe_pkg::rf_addr_t addr, input string name);
    @(negedge clk);
    rf_raddr_i = addr;
    exp_reg    = model_rf[addr];
    test_name  = name;
    chk_reg    = 1'b1;
    @(negedge clk);
    chk_reg = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_reg_value : assert property (@(posedge clk) disable iff (rst_i)
    chk_reg |-> (rf_rdata_o == exp_reg)
  ) else begin
    val_errs++;
    $display("Fail %s: expected %h, actual %h", test_name, exp_reg, $sampled(rf_rdata_o));
  end

  a_cfg_value : assert property (@(posedge clk) disable iff (rst_i)
    chk_cfg |-> (cfg_rdata_o == exp_cfg)
  ) else begin
    val_errs++;
    $display("Fail %s: expected %h, actual %h", test_name, exp_cfg, $sampled(cfg_rdata_o));
  end

  // The end-of-sequence flag travels with its instruction
  a_last_op : assert property (@(posedge clk) disable iff (rst_i)
    wb_valid_o |-> (last_op_o == exp_last)
  ) else begin
    val_errs++;
    $display("Fail last_op: expected %h, actual %h", exp_last, $sampled(last_op_o));
  end

  // A waiting load keeps its request up, stalls and blocks execute
  a_lsu_wait : assert property (@(posedge clk) disable iff (rst_i)
    lsu_wait_chk |-> (lsu_valid_o && data_stall_o && !wb_valid_o && !ex_ready_o)
  ) else begin
    proto_errs++;
    $display("A waiting load did not request the LSU, stall write-back and block execute");
  end

  a_mpu_fault : assert property (@(posedge clk) disable iff (rst_i)
    (lsu_valid_i && lsu_mpu_status_i != wb_pipe_pkg::MPU_OK) |-> (wb_valid_o && abort_op_o)
  ) else begin
    proto_errs++;
    $display("A faulted load did not retire with abort raised");
  end

  a_xif_wait : assert property (@(posedge clk) disable iff (rst_i)
    xif_wait_chk |-> (xif_result_ready_o && !wb_valid_o && !ex_ready_o)
  ) else begin
    proto_errs++;
    $display("A coprocessor instruction was not ready for its result or retired early");
  end

  a_xif_exc : assert property (@(posedge clk) disable iff (rst_i)
    (xif_result_valid_i && xif_result_exc_i) |-> (wb_valid_o && abort_op_o)
  ) else begin
    proto_errs++;
    $display("A coprocessor exception did not retire with abort raised");
  end

  // Clean instructions never abort
  a_no_abort : assert property (@(posedge clk) disable iff (rst_i)
    abort_op_o |-> abort_ok
  ) else begin
    proto_errs++;
    $display("Abort rose on an instruction that should retire cleanly");
  end

  a_halt : assert property (@(posedge clk) disable iff (rst_i)
    halt_chk |-> !wb_valid_o
  ) else begin
    proto_errs++;
    $display("An instruction retired while write-back was halted");
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    lfsr_state = 32'h6e0c_a1b5;
    rst_i = 1'b1;
    ex_valid_i = 1'b0;
    ex_src_i = wb_pipe_pkg::SRC_EXE;
    ex_rf_we_i = 1'b0;
    ex_rf_waddr_i = '0;
    ex_wdata_i = '0;
    ex_last_op_i = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_rdata_i = '0;
    lsu_mpu_status_i = wb_pipe_pkg::MPU_OK;
    xif_result_valid_i = 1'b0;
    xif_result_i = '0;
    xif_result_exc_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = wb_pipe_pkg::CFG_HALT;
    cfg_wdata_i = '0;
    rf_raddr_i = '0;
    {chk_reg, chk_cfg, lsu_wait_chk, xif_wait_chk, halt_chk, abort_ok, exp_last} = '0;
    exp_reg = '0;
    exp_cfg = '0;
    val_errs = 0;
    proto_errs = 0;
    model_retires = 0;
    xif_word = '0;
    for (int i = 0; i < `WB_RF_NREGS; i++) model_rf[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // Execute results, x0 included by chance and once on purpose
    for (int i = 0; i < EXE_OPS; i++) begin
      rnd = rand_bits(`WB_RF_AW);
      addr_a = rnd[`WB_RF_AW-1:0];
      data_a = rand_bits(32);
      send_op(wb_pipe_pkg::SRC_EXE, 1'b1, addr_a, data_a);
      wait_retire();
      model_write(addr_a, data_a);
      expect_reg(addr_a, "exe_write");
    end
    send_op(wb_pipe_pkg::SRC_EXE, 1'b1, '0, rand_bits(32));
    wait_retire();
    expect_reg('0, "exe_x0");
    addr_a = rand_reg();
    send_op(wb_pipe_pkg::SRC_EXE, 1'b0, addr_a, rand_bits(32));
    wait_retire();
    expect_reg(addr_a, "exe_no_we");

    // Load that waits for its data
    addr_a = rand_reg();
    send_op(wb_pipe_pkg::SRC_LSU, 1'b1, addr_a, rand_bits(32));
    lsu_wait_chk = 1'b1;
    repeat (LSU_WAIT) @(negedge clk);
    lsu_wait_chk = 1'b0;
    data_a = rand_bits(32);
    lsu_respond(data_a, wb_pipe_pkg::MPU_OK);
    model_write(addr_a, data_a);
    expect_reg(addr_a, "load_data");

    // Faulted load leaves the destination alone
    abort_ok = 1'b1;
    send_op(wb_pipe_pkg::SRC_LSU, 1'b1, addr_a, rand_bits(32));
    lsu_respond(rand_bits(32), wb_pipe_pkg::MPU_RE_FAULT);
    abort_ok = 1'b0;
    expect_reg(addr_a, "mpu_fault");

    // Coprocessor result after a wait
    addr_a = rand_reg();
    send_op(wb_pipe_pkg::SRC_XIF, 1'b1, addr_a, rand_bits(32));
    xif_wait_chk = 1'b1;
    repeat (XIF_WAIT) @(negedge clk);
    xif_wait_chk = 1'b0;
    xif_word.data = rand_bits(32);
    xif_respond(xif_word, 1'b0);
    model_write(addr_a, xif_word.data);
    expect_reg(addr_a, "xif_data");

    // Coprocessor exception carries its code in the result word
    rnd = rand_bits(6);
    exc_code = (rnd[5:0] == '0) ? 6'd1 : rnd[5:0];
    rnd = rand_bits(`WB_XLEN - 6);
    xif_word.exc.code = exc_code;
    xif_word.exc.tval_lo = rnd[`WB_XLEN-7:0];
    abort_ok = 1'b1;
    send_op(wb_pipe_pkg::SRC_XIF, 1'b1, addr_a, rand_bits(32));
    xif_wait_chk = 1'b1;
    repeat (XIF_WAIT) @(negedge clk);
    xif_wait_chk = 1'b0;
    xif_respond(xif_word, 1'b1);
    abort_ok = 1'b0;
    expect_reg(addr_a, "xif_exc_reg");
    expect_cfg(wb_pipe_pkg::CFG_EXC, {26'd0, exc_code}, "xif_exc_code");

    // Pointer replaces exactly one execute result
    addr_a = rand_reg();
    addr_b = rand_reg();
    if (addr_b == addr_a) addr_b = addr_a ^ 5'h10;
    rnd = rand_bits(32);
    write_cfg(wb_pipe_pkg::CFG_PTR, rnd);
    send_op(wb_pipe_pkg::SRC_EXE, 1'b1, addr_a, rand_bits(32));
    wait_retire();
    model_write(addr_a, rnd);
    data_a = rand_bits(32);
    send_op(wb_pipe_pkg::SRC_EXE, 1'b1, addr_b, data_a);
    wait_retire();
    model_write(addr_b, data_a);
    expect_reg(addr_a, "ptr_override");
    expect_reg(addr_b, "ptr_consumed");

    // Halt freezes the held instruction until it is released
    write_cfg(wb_pipe_pkg::CFG_RETIRE, '0);
    model_retires = 0;
    write_cfg(wb_pipe_pkg::CFG_HALT, 32'd1);
    halt_chk = 1'b1;
    addr_a = rand_reg();
    data_a = rand_bits(32);
    send_op(wb_pipe_pkg::SRC_EXE, 1'b1, addr_a, data_a);
    repeat (HALT_CYCLES) @(negedge clk);
    expect_reg(addr_a, "halt_no_write");
    halt_chk = 1'b0;
    write_cfg(wb_pipe_pkg::CFG_HALT, '0);
    wait_retire();
    model_write(addr_a, data_a);
    expect_reg(addr_a, "halt_release");
    addr_b = rand_reg();
    data_a = rand_bits(32);
    // Final instruction closes the sequence
    ex_last_op_i = 1'b1;
    exp_last = 1'b1;
    send_op(wb_pipe_pkg::SRC_EXE, 1'b1, addr_b, data_a);
    wait_retire();
    model_write(addr_b, data_a);
    expect_cfg(wb_pipe_pkg::CFG_RETIRE, model_retires, "retire_count");
    ex_last_op_i = 1'b0;
    exp_last = 1'b0;

    @(negedge clk);
    $display("Tests done: %0d value errors, %0d other errors", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/wb_pipe_pkg.sv
hw/wb_xif_pkg.sv
hw/ex_wb_pipe_reg.sv
hw/wb_stage.sv
hw/wb_ctrl_regs.sv
hw/regfile.sv
hw/wb_top.sv
testbench/tb_wb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the write-back testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_wb_top \
  -o sim_wb

./obj_dir/sim_wb | tee sim.log

if grep -qx ">>> PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
